// ==== verilog/cfg_capture_params.svh ====
// widths, FIFO depths and the sequence window of the configuration capture unit
`ifndef CFG_CAPTURE_PARAMS_SVH
`define CFG_CAPTURE_PARAMS_SVH

// ----------------------------------------
// response word fields
// ----------------------------------------
`define CFG_DATA_W      32
`define CFG_OFFSET_W    16
`define CFG_SHIFT_W     4

// hop count sits in the low data bits
`define CFG_HOPS_W      8

// ----------------------------------------
// sequence window of this engine
// ----------------------------------------
`define CFG_SEQ_BASE    16
`define CFG_SEQ_LEN     8

// ----------------------------------------
// FIFO sizing, shared by both queues
// ----------------------------------------
`define CFG_FIFO_DEPTH  16
`define CFG_PROG_THRESH 8

`endif

// ==== verilog/cfg_capture_pkg.sv ====
// buffer class enum and stored response word struct
`include "cfg_capture_params.svh"

package cfg_capture_pkg;

    // ----------------------------------------
    // buffer classes on the response bus
    // ----------------------------------------
    typedef enum logic [1:0] {
        STRUCT_INVALID      = 2'd0,
        STRUCT_CU_SETUP     = 2'd1,
        STRUCT_ENGINE_SETUP = 2'd2,
        STRUCT_KERNEL_DATA  = 2'd3
    } buffer_class_e;

    // ----------------------------------------
    // word kept in the response FIFO
    // ----------------------------------------
    // class, shift and raw offset are dropped after the filter,
    // only the resolved sequence number travels on
    typedef struct packed {
        logic [`CFG_OFFSET_W-1:0] seq;
        logic [`CFG_DATA_W-1:0]   data;
    } resp_word_t;

    localparam int RESP_WORD_W = $bits(resp_word_t);

endpackage

// ==== verilog/fifo_if.sv ====
// FIFO interface with writer, reader and storage modports
`timescale 1ns/1ps

interface fifo_if #(
    parameter int WIDTH = 8
);

    // writer side
    logic             wr_en;
    logic [WIDTH-1:0] din;

    // reader side
    logic             rd_en;

    // driven by the storage
    logic             full;
    logic             prog_full;
    logic             empty;
    logic [WIDTH-1:0] dout;
    logic             valid;

    modport writer (
        output wr_en, din,
        input  full, prog_full
    );

    modport reader (
        output rd_en,
        input  empty, dout, valid
    );

    modport storage (
        input  wr_en, din, rd_en,
        output full, prog_full, empty, dout, valid
    );

endinterface

// ==== verilog/sync_fifo.sv ====
// synchronous register-array FIFO with prog_full and registered read valid
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input logic       ap_clk,
    input logic       rst_n,
    fifo_if.storage   port
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // ----------------------------------------
    // status flags
    // ----------------------------------------
    assign port.full      = (count == CNT_W'(DEPTH));
    assign port.empty     = (count == '0);
    assign port.prog_full = (count >= CNT_W'(PROG_THRESH));

    // overflow and underflow requests are dropped here
    assign do_wr = port.wr_en && !port.full;
    assign do_rd = port.rd_en && !port.empty;

    // ----------------------------------------
    // pointers, fill count and read valid
    // ----------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            port.valid <= 1'b0;
        end else begin
            port.valid <= do_rd;
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // storage and registered read data
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= port.din;
        end
        // dout holds the popped entry while valid is high
        if (do_rd) begin
            port.dout <= mem[rd_ptr];
        end
    end

endmodule

// ==== verilog/response_filter.sv ====
// input register, sequence number and class/window filter for the response FIFO
`timescale 1ns/1ps
`include "cfg_capture_params.svh"

module response_filter
    import cfg_capture_pkg::*;
(
    input logic                     ap_clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input buffer_class_e            in_class,
    input logic [`CFG_OFFSET_W-1:0] in_offset,
    input logic [`CFG_SHIFT_W-1:0]  in_shift,
    input logic [`CFG_DATA_W-1:0]   in_data,
    fifo_if.writer                  push
);

    localparam int OFFSET_W = `CFG_OFFSET_W;
    localparam logic [OFFSET_W-1:0] SEQ_LO = OFFSET_W'(`CFG_SEQ_BASE);
    localparam logic [OFFSET_W-1:0] SEQ_HI = OFFSET_W'(`CFG_SEQ_BASE + `CFG_SEQ_LEN);

    logic                     valid_q;
    buffer_class_e            class_q;
    logic [`CFG_OFFSET_W-1:0] offset_q;
    logic [`CFG_SHIFT_W-1:0]  shift_q;
    logic [`CFG_DATA_W-1:0]   data_q;
    logic [`CFG_OFFSET_W-1:0] seq_num;
    logic                     class_ok;
    logic                     window_ok;
    resp_word_t               word;

    // ----------------------------------------
    // input register
    // ----------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        class_q  <= in_class;
        offset_q <= in_offset;
        shift_q  <= in_shift;
        data_q   <= in_data;
    end

    // ----------------------------------------
    // filter
    // ----------------------------------------
    assign seq_num   = offset_q >> shift_q;
    assign class_ok  = (class_q == STRUCT_CU_SETUP) || (class_q == STRUCT_ENGINE_SETUP);
    // half-open window [base, base + len)
    assign window_ok = (seq_num >= SEQ_LO) && (seq_num < SEQ_HI);

    assign word.seq  = seq_num;
    assign word.data = data_q;

    assign push.wr_en = valid_q && class_ok && window_ok;
    assign push.din   = word;

endmodule

// ==== verilog/config_sequencer.sv ====
// pop control, one-hot sequence tracker, hop capture and record emission
`timescale 1ns/1ps
`include "cfg_capture_params.svh"

module config_sequencer
    import cfg_capture_pkg::*;
(
    input logic     ap_clk,
    input logic     rst_n,
    fifo_if.reader  words,
    fifo_if.writer  records
);

    localparam int OFFSET_W = `CFG_OFFSET_W;
    localparam int LEN      = `CFG_SEQ_LEN;
    localparam logic [OFFSET_W-1:0] SEQ_BASE = OFFSET_W'(`CFG_SEQ_BASE);

    resp_word_t             word;
    logic                   is_base;
    logic                   last;
    logic [LEN-1:0]         tracker;
    logic                   emit;
    logic [`CFG_HOPS_W-1:0] hops_q;
    logic [`CFG_HOPS_W-1:0] rec_hops;

    // ----------------------------------------
    // pop control
    // ----------------------------------------
    // hold off while the output queue fills up or a record is on its way out
    assign words.rd_en = !words.empty && !records.prog_full && !emit;

    assign word    = words.dout;
    assign is_base = (word.seq == SEQ_BASE);
    assign last    = tracker[LEN-1];

    // ----------------------------------------
    // one-hot tracker and emit flag
    // ----------------------------------------
    always_ff @(posedge ap_clk or negedge rst_n) begin
        if (!rst_n) begin
            tracker <= '0;
            emit    <= 1'b0;
        end else begin
            emit <= last;
            if (words.valid && is_base) begin
                // restart, also in the middle of a sequence
                tracker <= LEN'(1);
            end else if (words.valid) begin
                // idle tracker stays zero, so stray words drop out here
                tracker <= tracker << 1;
            end else if (last) begin
                tracker <= '0;
            end
        end
    end

    // ----------------------------------------
    // hop capture and record register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (words.valid && is_base) begin
            hops_q <= word.data[`CFG_HOPS_W-1:0];
        end
        // snapshot so a base word arriving with the emit cannot corrupt the record
        if (last) begin
            rec_hops <= hops_q;
        end
    end

    assign records.wr_en = emit;
    assign records.din   = rec_hops;

endmodule

// ==== verilog/cfg_capture_top.sv ====
// configuration capture top level: filter, response FIFO, sequencer, output FIFO
`timescale 1ns/1ps
`include "cfg_capture_params.svh"

module cfg_capture_top
    import cfg_capture_pkg::*;
(
    input  logic                     ap_clk,
    input  logic                     rst_n,
    input  logic                     resp_valid,
    input  buffer_class_e            resp_class,
    input  logic [`CFG_OFFSET_W-1:0] resp_offset,
    input  logic [`CFG_SHIFT_W-1:0]  resp_shift,
    input  logic [`CFG_DATA_W-1:0]   resp_data,
    input  logic                     cfg_rd_en,
    output logic                     resp_prog_full,
    output logic                     cfg_valid,
    output logic [`CFG_HOPS_W-1:0]   cfg_hops
);

    fifo_if #(.WIDTH(RESP_WORD_W)) resp_q ();
    fifo_if #(.WIDTH(`CFG_HOPS_W)) cfg_q ();

    // ----------------------------------------
    // response path
    // ----------------------------------------
    response_filter u_filter (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .in_valid  (resp_valid),
        .in_class  (resp_class),
        .in_offset (resp_offset),
        .in_shift  (resp_shift),
        .in_data   (resp_data),
        .push      (resp_q.writer)
    );

    sync_fifo #(
        .WIDTH       (RESP_WORD_W),
        .DEPTH       (`CFG_FIFO_DEPTH),
        .PROG_THRESH (`CFG_PROG_THRESH)
    ) u_resp_fifo (
        .ap_clk (ap_clk),
        .rst_n  (rst_n),
        .port   (resp_q.storage)
    );

    // ----------------------------------------
    // sequencing and record queue
    // ----------------------------------------
    config_sequencer u_sequencer (
        .ap_clk  (ap_clk),
        .rst_n   (rst_n),
        .words   (resp_q.reader),
        .records (cfg_q.writer)
    );

    sync_fifo #(
        .WIDTH       (`CFG_HOPS_W),
        .DEPTH       (`CFG_FIFO_DEPTH),
        .PROG_THRESH (`CFG_PROG_THRESH)
    ) u_cfg_fifo (
        .ap_clk (ap_clk),
        .rst_n  (rst_n),
        .port   (cfg_q.storage)
    );

    // consumer side of the record queue
    assign cfg_q.rd_en    = cfg_rd_en;
    assign cfg_valid      = cfg_q.valid;
    assign cfg_hops       = cfg_q.dout;
    // lets the source throttle itself
    assign resp_prog_full = resp_q.prog_full;

endmodule

// ==== tb/cfg_capture_asserts.sv ====
// concurrent assertions on FIFO writes, tracker shape and record read valid
`timescale 1ns/1ps
`include "cfg_capture_params.svh"

module cfg_capture_asserts (
    input logic                    ap_clk,
    input logic                    rst_n,
    input logic                    resp_wr_en,
    input logic                    resp_full,
    input logic                    cfg_wr_en,
    input logic                    cfg_full,
    input logic [`CFG_SEQ_LEN-1:0] tracker,
    input logic                    cfg_valid,
    input logic                    cfg_rd_en
);

    // ----------------------------------------
    // FIFO safety
    // ----------------------------------------
    resp_no_overflow: assert property (@(posedge ap_clk) disable iff (!rst_n)
        resp_wr_en |-> !resp_full)
        else $error("response FIFO written while full");

    cfg_no_overflow: assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_wr_en |-> !cfg_full)
        else $error("record FIFO written while full");

    // ----------------------------------------
    // tracker and consumer side
    // ----------------------------------------
    tracker_shape: assert property (@(posedge ap_clk) disable iff (!rst_n)
        $onehot0(tracker))
        else $error("sequence tracker has more than one bit set");

    // read valid only follows a read strobe
    valid_after_read: assert property (@(posedge ap_clk) disable iff (!rst_n)
        cfg_valid |-> $past(cfg_rd_en))
        else $error("cfg_valid rose without a read strobe in the cycle before");

endmodule

// ==== tb/tb_cfg_capture.sv ====
// testbench: clock, reset, random stimulus, reference model, checks and watchdog
`timescale 1ns/1ps
`include "cfg_capture_params.svh"

module tb_cfg_capture
    import cfg_capture_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_WORDS    = 3000;
    localparam int DRAIN_CYCLES = 2000;
    localparam int BASE         = `CFG_SEQ_BASE;
    localparam int LEN          = `CFG_SEQ_LEN;

    logic                     ap_clk;
    logic                     rst_n;
    logic                     resp_valid;
    buffer_class_e            resp_class;
    logic [`CFG_OFFSET_W-1:0] resp_offset;
    logic [`CFG_SHIFT_W-1:0]  resp_shift;
    logic [`CFG_DATA_W-1:0]   resp_data;
    logic                     cfg_rd_en;
    logic                     resp_prog_full;
    logic                     cfg_valid;
    logic [`CFG_HOPS_W-1:0]   cfg_hops;

    logic [31:0]            rng_state;
    logic [`CFG_HOPS_W-1:0] exp_q [$];
    // position in the current sequence, -1 while idle
    int                     model_pos;
    logic [`CFG_HOPS_W-1:0] model_hops;
    int                     stall_left;
    bit                     pass_shown;
    bit                     fail_shown;

    cfg_capture_top DUT (.*);

    bind cfg_capture_top cfg_capture_asserts u_asserts (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp_wr_en (resp_q.wr_en),
        .resp_full  (resp_q.full),
        .cfg_wr_en  (cfg_q.wr_en),
        .cfg_full   (cfg_q.full),
        .tracker    (u_sequencer.tracker),
        .cfg_valid  (cfg_valid),
        .cfg_rd_en  (cfg_rd_en)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_failure(input string msg);
        fail_shown = 1'b1;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    // ----------------------------------------
    // reference model: filter, then tracker
    // ----------------------------------------
    task automatic model_word(input buffer_class_e cls, input logic [15:0] off,
                              input logic [3:0] sh, input logic [31:0] data);
        int seq;
        seq = int'(off >> sh);
        if (cls != STRUCT_CU_SETUP && cls != STRUCT_ENGINE_SETUP) return;
        if (seq < BASE || seq >= BASE + LEN) return;
        if (seq == BASE) begin
            model_pos  = 0;
            model_hops = data[`CFG_HOPS_W-1:0];
        end else if (model_pos >= 0) begin
            model_pos++;
        end
        if (model_pos == LEN - 1) begin
            exp_q.push_back(model_hops);
            model_pos = -1;
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic drive_word();
        logic [31:0] r;
        int          seq;
        int          sh;
        int          extra;
        r     = next_rand();
        extra = 0;
        // mostly setup classes
        case (r[2:0])
            3'd0:             resp_class = STRUCT_INVALID;
            3'd1:             resp_class = STRUCT_KERNEL_DATA;
            3'd2, 3'd3, 3'd4: resp_class = STRUCT_CU_SETUP;
            default:          resp_class = STRUCT_ENGINE_SETUP;
        endcase
        case (r[6:3])
            4'd0, 4'd1: seq = BASE;
            4'd2:       seq = BASE - 1 - int'(r[8:7]);
            4'd3:       seq = BASE + LEN + int'(r[8:7]);
            // doubled number, only the larger shift brings it into the window
            4'd4: begin
                seq   = 2 * (BASE + 1 + int'(r[9:7]) % (LEN - 1));
                extra = 1;
            end
            default:    seq = BASE + 1 + int'(r[9:7]) % (LEN - 1);
        endcase
        sh          = int'(r[12:10]);
        resp_offset = 16'(seq << sh) | (r[31:16] & 16'((1 << sh) - 1));
        // sometimes the shift alone pushes the number out
        resp_shift  = 4'(sh + extra + ((r[15:13] == 3'd0) ? 1 : 0));
        resp_data   = next_rand();
        resp_valid  = 1'b1;
        model_word(resp_class, resp_offset, resp_shift, resp_data);
    endtask

    task automatic drive_read();
        logic [31:0] r;
        r = next_rand();
        if (stall_left > 0) begin
            cfg_rd_en = 1'b0;
            stall_left--;
        end else if (r[7:0] == 8'd0) begin
            // long enough for the record queue to reach prog_full
            cfg_rd_en  = 1'b0;
            stall_left = 600 + int'(r[15:8]);
        end else begin
            cfg_rd_en = r[31];
        end
    endtask

    initial begin
        ap_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
    end

    initial begin
        int          sent;
        int          waited;
        int          full_cycles;
        logic [31:0] r;
        rng_state   = 32'he286_0df7;
        rst_n       = 1'b0;
        resp_valid  = 1'b0;
        resp_class  = STRUCT_INVALID;
        resp_offset = '0;
        resp_shift  = '0;
        resp_data   = '0;
        cfg_rd_en   = 1'b0;
        model_pos   = -1;
        model_hops  = '0;
        stall_left  = 0;
        pass_shown  = 1'b0;
        fail_shown  = 1'b0;
        sent        = 0;
        waited      = 0;
        full_cycles = 0;
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        assert (!resp_prog_full && !cfg_valid) else begin
            report_failure($sformatf("Fail at time %0t: outputs not low in reset", $time));
        end
        rst_n = 1'b1;
        while (sent < NUM_WORDS) begin
            @(negedge ap_clk);
            drive_read();
            resp_valid = 1'b0;
            r = next_rand();
            if (resp_prog_full) begin
                full_cycles++;
            end
            // source pauses on resp_prog_full
            if (!resp_prog_full && r[1:0] != 2'd0) begin
                drive_word();
                sent++;
            end
        end
        @(negedge ap_clk);
        resp_valid = 1'b0;
        cfg_rd_en  = 1'b1;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge ap_clk);
            waited++;
        end
        // room for a stray extra record to show up
        repeat (40) @(negedge ap_clk);
        assert (full_cycles > 0) else begin
            report_failure("resp_prog_full never rose during the consumer stalls");
        end
        assert (!resp_prog_full) else begin
            report_failure($sformatf("Fail at time %0t: resp_prog_full high after drain",
                                     $time));
        end
        assert (exp_q.size() == 0) begin
            pass_shown = 1'b1;
            $display("=== PASS ===");
            $finish;
        end else begin
            report_failure($sformatf("%0d expected records never came out", exp_q.size()));
        end
    end

    // ----------------------------------------
    // record checker
    // ----------------------------------------
    always @(negedge ap_clk) begin
        logic [`CFG_HOPS_W-1:0] expected;
        if (rst_n && cfg_valid) begin
            assert (exp_q.size() != 0) else begin
                report_failure("a record came out while none was expected");
            end
            expected = exp_q.pop_front();
            assert (cfg_hops == expected) else begin
                report_failure($sformatf("Fail at time %0t: record hops %0d, expected %0d",
                                         $time, cfg_hops, expected));
            end
        end
    end

    initial begin
        #((NUM_WORDS * 40 + DRAIN_CYCLES) * CLK_PERIOD);
        report_failure("timeout: the run did not finish in the allowed time");
    end

    // a bound assertion may end the run early
    final begin
        if (!pass_shown && !fail_shown) begin
            $display("=== FAIL ===");
        end
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/cfg_capture_pkg.sv
verilog/fifo_if.sv
verilog/sync_fifo.sv
verilog/response_filter.sv
verilog/config_sequencer.sv
verilog/cfg_capture_top.sv
tb/cfg_capture_asserts.sv
tb/tb_cfg_capture.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cfg_capture
FILELIST  := vlog.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)
